//--- build.f
core_isa_pkg.sv
core_bus_pkg.sv
program_memory.sv
control_unit.sv
instruction_decoder.sv
channel_alu.sv
register_file.sv
host_interface.sv
core_top.sv
tb_core_assertions.sv
tb_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_core
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core import core_isa_pkg::*; import core_bus_pkg::*; ();

    localparam int MAX_CHANNELS = 8;
    localparam int PROGRAM_DEPTH = 256;
    localparam int ACK_TIMEOUT = 16;
    localparam int DONE_POLLS = 200;
    localparam logic [11:0] CTRL_ADDR = {REGION_CONTROL, 10'd0};

    logic clock;
    logic rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic [15:0] lfsr_state;
    logic [31:0] prog_image [PROGRAM_DEPTH];
    int prog_length;

    // Expected register contents, and which registers the program wrote
    logic [31:0] model_regs [MAX_CHANNELS][NUM_REGS];
    logic model_written [MAX_CHANNELS][NUM_REGS];

    core_top #(
        .MAX_CHANNELS(MAX_CHANNELS),
        .PROGRAM_DEPTH(PROGRAM_DEPTH)
    ) u_dut (
        .clock(clock),
        .rst(rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s = 0x%08h, expected 0x%08h",
                                name, actual, expected));
        end
    endtask

    task automatic check_status(input logic [31:0] status, input logic [3:0] exp_channels,
                                input logic exp_done, input logic exp_busy);
        check_word("status.n_channels", 32'(status[3:0]), 32'(exp_channels));
        check_word("status.done", 32'(status[STATUS_DONE_BIT]), 32'(exp_done));
        check_word("status.busy", 32'(status[STATUS_BUSY_BIT]), 32'(exp_busy));
    endtask

    // Called 2 ns after a rising edge and returns at the same point of a later cycle
    task automatic bus_cycle(input logic we, input logic [11:0] adr,
                             input logic [31:0] dat, output logic [31:0] data);
        int waited;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        waited = 0;
        do begin
            @(posedge clock);
            #2;
            waited++;
        end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
        if (!wb_rsp.ack) begin
            abort_run($sformatf("No ack from the core for address 0x%03h", adr));
        end
        data = wb_rsp.dat;
        wb_req = '0;
        // Leave stb low for a cycle after each ack
        @(posedge clock);
        #2;
    endtask

    task automatic wb_write(input logic [11:0] adr, input logic [31:0] dat);
        logic [31:0] unused_data;
        bus_cycle(1'b1, adr, dat, unused_data);
    endtask

    task automatic wb_read(input logic [11:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'd0, data);
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [31:0] make_instr(input opcode_t opcode, input int rd,
                                               input int ra, input int rb);
        instr_t word;
        word = '0;
        word.opcode = opcode;
        word.rd = reg_idx_t'(rd);
        word.ra = reg_idx_t'(ra);
        word.rb = reg_idx_t'(rb);
        return word;
    endfunction

    // Runs the program image one instruction at a time across the channels
    function automatic void run_model(input int n_channels);
        int pc;
        instr_t word;
        logic [31:0] constant;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic writes;
        for (int ch = 0; ch < MAX_CHANNELS; ch++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                model_written[ch][r] = 1'b0;
            end
        end
        pc = 0;
        for (int step = 0; step < PROGRAM_DEPTH; step++) begin
            word = instr_t'(prog_image[pc]);
            constant = prog_image[(pc + 1) % PROGRAM_DEPTH];
            if (word.opcode == STOP) begin
                break;
            end
            for (int ch = 0; ch < n_channels; ch++) begin
                a = model_regs[ch][word.ra];
                b = model_regs[ch][word.rb];
                writes = 1'b1;
                result = '0;
                case (word.opcode)
                    ADD: result = a + b;
                    SUB: result = a - b;
                    AND: result = a & b;
                    OR: result = a | b;
                    XOR: result = a ^ b;
                    LDC: result = constant;
                    LDCH: result = 32'(ch);
                    default: writes = 1'b0;
                endcase
                if (writes) begin
                    model_regs[ch][word.rd] = result;
                    model_written[ch][word.rd] = 1'b1;
                end
            end
            pc = (pc + ((word.opcode == LDC) ? 2 : 1)) % PROGRAM_DEPTH;
        end
    endfunction

    task automatic load_program();
        for (int i = 0; i < prog_length; i++) begin
            wb_write(12'(i), prog_image[i]);
        end
    endtask

    task automatic verify_program();
        logic [31:0] value;
        for (int i = 0; i < prog_length; i++) begin
            wb_read(12'(i), value);
            check_word($sformatf("program word %0d", i), value, prog_image[i]);
        end
    endtask

    task automatic start_run(input int n_channels);
        wb_write(CTRL_ADDR, 32'(n_channels) | (32'd1 << CTRL_RUN_BIT));
    endtask

    task automatic wait_done(input int n_channels);
        logic [31:0] status;
        int polls;
        polls = 0;
        do begin
            wb_read(CTRL_ADDR, status);
            polls++;
        end while (!status[STATUS_DONE_BIT] && polls < DONE_POLLS);
        if (!status[STATUS_DONE_BIT]) begin
            abort_run("The core did not report done within the polling limit");
        end
        check_status(status, 4'(n_channels), 1'b1, 1'b0);
    endtask

    task automatic check_registers(input int n_channels);
        logic [31:0] value;
        run_model(n_channels);
        for (int ch = 0; ch < n_channels; ch++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (model_written[ch][r]) begin
                    wb_read({REGION_REGFILE, 4'd0, 3'(ch), 3'(r)}, value);
                    check_word($sformatf("channel %0d r%0d", ch, r), value,
                               model_regs[ch][r]);
                end
            end
        end
    endtask

    task automatic run_and_check(input int n_channels);
        start_run(n_channels);
        wait_done(n_channels);
        check_registers(n_channels);
    endtask

    // Word 4 is the LDC constant and also a valid LDCH r2 encoding
    task automatic build_mixed_program(input logic [31:0] k1);
        prog_image[0] = make_instr(LDCH, 1, 0, 0);
        prog_image[1] = make_instr(LDC, 2, 0, 0);
        prog_image[2] = k1;
        prog_image[3] = make_instr(LDC, 6, 0, 0);
        prog_image[4] = make_instr(LDCH, 2, 0, 0);
        prog_image[5] = make_instr(ADD, 3, 1, 2);
        prog_image[6] = make_instr(SUB, 4, 2, 1);
        prog_image[7] = make_instr(AND, 5, 3, 6);
        prog_image[8] = make_instr(OR, 7, 4, 1);
        prog_image[9] = make_instr(XOR, 0, 7, 3);
        prog_image[10] = make_instr(NOP, 0, 0, 0);
        prog_image[11] = make_instr(STOP, 0, 0, 0);
        prog_length = 12;
    endtask

    task automatic build_random_program();
        logic [31:0] k1;
        logic [31:0] k2;
        random_bits(32, k1);
        random_bits(32, k2);
        prog_image[0] = make_instr(LDC, 1, 0, 0);
        prog_image[1] = k1;
        prog_image[2] = make_instr(LDC, 2, 0, 0);
        prog_image[3] = k2;
        prog_image[4] = make_instr(LDCH, 3, 0, 0);
        prog_image[5] = make_instr(ADD, 4, 1, 3);
        prog_image[6] = make_instr(XOR, 5, 2, 4);
        prog_image[7] = make_instr(SUB, 6, 5, 1);
        prog_image[8] = make_instr(OR, 7, 6, 3);
        prog_image[9] = make_instr(AND, 0, 7, 2);
        prog_image[10] = make_instr(STOP, 0, 0, 0);
        prog_length = 11;
    endtask

    initial begin
        logic [31:0] status;
        logic [31:0] value;
        rst = 1'b1;
        wb_req = '0;
        lfsr_state = 16'd60;
        prog_length = 0;
        repeat (3) @(posedge clock);
        #2;
        rst = 1'b0;

        wb_read(CTRL_ADDR, status);
        check_status(status, 4'd1, 1'b0, 1'b0);

        random_bits(32, value);
        build_mixed_program(value);
        load_program();
        verify_program();
        run_and_check(4);

        build_random_program();
        load_program();
        run_and_check(1);
        build_random_program();
        load_program();
        run_and_check(8);
        random_bits(3, value);
        build_random_program();
        load_program();
        run_and_check(int'(value) + 1);

        // A program write during a run must not land in memory
        // Had it landed, r1 of every channel would hold the channel index on the rerun
        start_run(8);
        wb_read(CTRL_ADDR, status);
        check_status(status, 4'd8, 1'b0, 1'b1);
        wb_write(12'd0, make_instr(LDCH, 1, 0, 0));
        wait_done(8);
        check_registers(8);
        wb_read(12'd0, value);
        check_word("program word 0", value, prog_image[0]);
        run_and_check(8);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core_assertions import core_isa_pkg::*; import core_bus_pkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  wb_req_t    wb_req,
    input  wb_rsp_t    wb_rsp,
    input  logic       busy,
    input  logic       done,
    input  issue_t     issue,
    input  logic [3:0] n_channels
);

    // The slave only answers a cycle in which the master requested
    ack_after_request: assert property (@(posedge clock) disable iff (rst)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack raised without cyc and stb in the previous cycle");

    busy_done_exclusive: assert property (@(posedge clock) disable iff (rst)
        !(busy && done))
        else $error("busy and done are high together");

    // Only active channels are ever issued
    issue_channel_active: assert property (@(posedge clock) disable iff (rst)
        issue.valid |-> ({1'b0, issue.channel} < n_channels))
        else $error("issued channel %0d is not below n_channels %0d",
                    issue.channel, n_channels);

endmodule

bind core_top tb_core_assertions u_assertions (
    .clock(clock),
    .rst(rst),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp),
    .busy(busy),
    .done(done),
    .issue(issue),
    .n_channels(n_channels)
);

`default_nettype wire

//--- core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top import core_isa_pkg::*; import core_bus_pkg::*; #(
    parameter int MAX_CHANNELS = 8,
    parameter int PROGRAM_DEPTH = 256
) (
    input  logic    clock,
    input  logic    rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH);
    localparam int NCH_WIDTH = $clog2(MAX_CHANNELS + 1);

    logic pm_wr_en;
    pm_index_t pm_wr_addr;
    logic [31:0] pm_wr_data;
    pm_index_t pm_rd_addr;
    logic [31:0] pm_rd_data;
    rf_addr_t rf_host_addr;
    logic [31:0] rf_host_data;
    logic [NCH_WIDTH-1:0] n_channels;
    logic run;
    logic busy;
    logic done;
    logic [PC_WIDTH-1:0] fetch_addr;
    instr_t [1:0] fetch_words;
    issue_t issue;
    decoded_op_t op;
    rf_addr_t ra_addr;
    rf_addr_t rb_addr;
    logic [31:0] ra_value;
    logic [31:0] rb_value;
    writeback_t writeback;

    host_interface #(
        .MAX_CHANNELS(MAX_CHANNELS)
    ) u_host_interface (
        .clock(clock),
        .rst(rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .busy(busy),
        .done(done),
        .pm_rd_data(pm_rd_data),
        .rf_host_data(rf_host_data),
        .pm_wr_en(pm_wr_en),
        .pm_wr_addr(pm_wr_addr),
        .pm_wr_data(pm_wr_data),
        .pm_rd_addr(pm_rd_addr),
        .rf_host_addr(rf_host_addr),
        .n_channels(n_channels),
        .run(run)
    );

    program_memory #(
        .PROGRAM_DEPTH(PROGRAM_DEPTH)
    ) u_program_memory (
        .clock(clock),
        .wr_en(pm_wr_en),
        .wr_addr(pm_wr_addr),
        .wr_data(pm_wr_data),
        .rd_addr(pm_rd_addr),
        .fetch_addr(fetch_addr),
        .rd_data(pm_rd_data),
        .fetch_words(fetch_words)
    );

    control_unit #(
        .PROGRAM_DEPTH(PROGRAM_DEPTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) u_control_unit (
        .clock(clock),
        .rst(rst),
        .run(run),
        .n_channels(n_channels),
        .fetch_words(fetch_words),
        .fetch_addr(fetch_addr),
        .issue(issue),
        .busy(busy),
        .done(done)
    );

    instruction_decoder u_instruction_decoder (
        .clock(clock),
        .rst(rst),
        .issue(issue),
        .op(op),
        .ra_addr(ra_addr),
        .rb_addr(rb_addr)
    );

    channel_alu u_channel_alu (
        .clock(clock),
        .rst(rst),
        .op(op),
        .ra_value(ra_value),
        .rb_value(rb_value),
        .wb(writeback)
    );

    register_file #(
        .MAX_CHANNELS(MAX_CHANNELS)
    ) u_register_file (
        .clock(clock),
        .wb(writeback),
        .ra_addr(ra_addr),
        .rb_addr(rb_addr),
        .host_addr(rf_host_addr),
        .ra_value(ra_value),
        .rb_value(rb_value),
        .host_data(rf_host_data)
    );

endmodule

`default_nettype wire

//--- host_interface.sv
`timescale 1ns/100ps
`default_nettype none

module host_interface import core_bus_pkg::*; import core_isa_pkg::*; #(
    parameter int MAX_CHANNELS = 8,
    localparam int NCH_WIDTH = $clog2(MAX_CHANNELS + 1)
) (
    input  logic                 clock,
    input  logic                 rst,
    input  wb_req_t              wb_req,
    output wb_rsp_t              wb_rsp,
    input  logic                 busy,
    input  logic                 done,
    input  logic [31:0]          pm_rd_data,
    input  logic [31:0]          rf_host_data,
    output logic                 pm_wr_en,
    output pm_index_t            pm_wr_addr,
    output logic [31:0]          pm_wr_data,
    output pm_index_t            pm_rd_addr,
    output rf_addr_t             rf_host_addr,
    output logic [NCH_WIDTH-1:0] n_channels,
    output logic                 run
);

    logic [1:0] region;
    logic ack;
    logic request;
    logic write_cycle;
    logic ctrl_write;
    logic channels_ok;
    logic [NCH_WIDTH-1:0] new_channels;
    logic [31:0] status;
    logic [31:0] read_data;

    assign region = wb_req.adr[REGION_MSB:REGION_LSB];

    // A request is taken once, in the cycle before its ack
    assign request = wb_req.cyc && wb_req.stb && !ack;
    assign write_cycle = request && wb_req.we && !busy;
    assign pm_wr_en = write_cycle && region == REGION_PROGRAM;
    assign ctrl_write = write_cycle && region == REGION_CONTROL;

    assign new_channels = wb_req.dat[NCH_WIDTH-1:0];
    assign channels_ok = new_channels != '0 && new_channels <= MAX_CHANNELS;

    assign pm_wr_addr = wb_req.adr[7:0];
    assign pm_rd_addr = wb_req.adr[7:0];
    assign pm_wr_data = wb_req.dat;
    assign rf_host_addr = '{channel: wb_req.adr[RF_CH_MSB:RF_CH_LSB],
                            index: wb_req.adr[RF_REG_MSB:RF_REG_LSB]};

    always_ff @(posedge clock) begin
        if (rst) begin
            ack <= 1'b0;
            run <= 1'b0;
            n_channels <= NCH_WIDTH'(1);
        end else begin
            ack <= request;
            run <= ctrl_write && wb_req.dat[CTRL_RUN_BIT];
            if (ctrl_write && channels_ok) begin
                n_channels <= new_channels;
            end
        end
    end

    // Read data is valid while ack is high since the master holds adr
    always_comb begin
        status = '0;
        status[NCH_WIDTH-1:0] = n_channels;
        status[STATUS_DONE_BIT] = done;
        status[STATUS_BUSY_BIT] = busy;
        case (region)
            REGION_PROGRAM: read_data = pm_rd_data;
            REGION_REGFILE: read_data = rf_host_data;
            REGION_CONTROL: read_data = status;
            default: read_data = '0;
        endcase
    end

    assign wb_rsp = '{ack: ack, dat: read_data};

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file import core_isa_pkg::*; #(
    parameter int MAX_CHANNELS = 8
) (
    input  logic        clock,
    input  writeback_t  wb,
    input  rf_addr_t    ra_addr,
    input  rf_addr_t    rb_addr,
    input  rf_addr_t    host_addr,
    output logic [31:0] ra_value,
    output logic [31:0] rb_value,
    output logic [31:0] host_data
);

    // One bank of general registers per channel
    logic [31:0] regs [MAX_CHANNELS][NUM_REGS];

    // Results commit at the edge where the write-back is valid
    always_ff @(posedge clock) begin
        if (wb.valid) begin
            regs[wb.channel][wb.rd] <= wb.value;
        end
    end

    // Operand reads are combinational so the ALU sees them in the decode cycle
    assign ra_value = regs[ra_addr.channel][ra_addr.index];
    assign rb_value = regs[rb_addr.channel][rb_addr.index];

    // Host read, held stable by the bus master until ack
    assign host_data = regs[host_addr.channel][host_addr.index];

endmodule

`default_nettype wire

//--- channel_alu.sv
`timescale 1ns/100ps
`default_nettype none

module channel_alu import core_isa_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  decoded_op_t op,
    input  logic [31:0] ra_value,
    input  logic [31:0] rb_value,
    output writeback_t  wb
);

    logic [31:0] result;
    logic writes_rd;
    writeback_t next_wb;

    always_comb begin
        writes_rd = 1'b1;
        case (op.opcode)
            ADD: begin
                result = ra_value + rb_value;
            end
            SUB: begin
                result = ra_value - rb_value;
            end
            AND: begin
                result = ra_value & rb_value;
            end
            OR: begin
                result = ra_value | rb_value;
            end
            XOR: begin
                result = ra_value ^ rb_value;
            end
            LDC: begin
                result = op.constant;
            end
            // Each channel sees its own index
            LDCH: begin
                result = 32'(op.channel);
            end
            default: begin
                result = '0;
                writes_rd = 1'b0;
            end
        endcase
    end

    always_comb begin
        next_wb.valid = op.valid && writes_rd;
        next_wb.channel = op.channel;
        next_wb.rd = op.rd;
        next_wb.value = result;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb <= next_wb;
        end
    end

endmodule

`default_nettype wire

//--- instruction_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instruction_decoder import core_isa_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  issue_t      issue,
    output decoded_op_t op,
    output rf_addr_t    ra_addr,
    output rf_addr_t    rb_addr
);

    opcode_t opcode;
    decoded_op_t next_op;

    // Anything outside the instruction set is treated as NOP
    always_comb begin
        case (opcode_t'(issue.instr.opcode))
            NOP, ADD, SUB, AND, OR, XOR, LDC, LDCH, STOP: begin
                opcode = opcode_t'(issue.instr.opcode);
            end
            default: begin
                opcode = NOP;
            end
        endcase
    end

    always_comb begin
        next_op.valid = issue.valid;
        next_op.opcode = opcode;
        next_op.rd = issue.instr.rd;
        next_op.ra = issue.instr.ra;
        next_op.rb = issue.instr.rb;
        next_op.channel = issue.channel;
        next_op.constant = issue.constant;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            op.valid <= 1'b0;
        end else begin
            op <= next_op;
        end
    end

    // Operand addresses come from the registered op so the values line up with it
    assign ra_addr = '{channel: op.channel, index: op.ra};
    assign rb_addr = '{channel: op.channel, index: op.rb};

endmodule

`default_nettype wire

//--- control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit import core_isa_pkg::*; #(
    parameter int PROGRAM_DEPTH = 256,
    parameter int MAX_CHANNELS = 8,
    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH),
    localparam int CH_WIDTH = $clog2(MAX_CHANNELS),
    localparam int NCH_WIDTH = $clog2(MAX_CHANNELS + 1)
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 run,
    input  logic [NCH_WIDTH-1:0] n_channels,
    input  instr_t [1:0]         fetch_words,
    output logic [PC_WIDTH-1:0]  fetch_addr,
    output issue_t               issue,
    output logic                 busy,
    output logic                 done
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        ISSUE,
        DRAIN
    } state_t;

    state_t state;
    logic [PC_WIDTH-1:0] pc;
    logic [CH_WIDTH-1:0] channel;
    logic [1:0] drain_count;
    logic is_stop;
    logic is_ldc;
    logic last_channel;

    assign is_stop = fetch_words[0].opcode == STOP;
    assign is_ldc = fetch_words[0].opcode == LDC;
    assign last_channel = channel == CH_WIDTH'(n_channels - 1'b1);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
            pc <= '0;
            channel <= '0;
            drain_count <= '0;
            done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (run) begin
                        state <= FETCH;
                        pc <= '0;
                        channel <= '0;
                        done <= 1'b0;
                    end
                end
                // Memory presents the word pair at pc during the first ISSUE cycle
                FETCH: begin
                    state <= ISSUE;
                end
                ISSUE: begin
                    if (is_stop) begin
                        state <= DRAIN;
                        drain_count <= '0;
                    end else if (last_channel) begin
                        channel <= '0;
                        // The constant word of an LDC is skipped
                        pc <= pc + (is_ldc ? PC_WIDTH'(2) : PC_WIDTH'(1));
                        state <= FETCH;
                    end else begin
                        channel <= channel + 1'b1;
                    end
                end
                // Wait for the last write-backs to reach the register file
                DRAIN: begin
                    if (drain_count == 2'd2) begin
                        done <= 1'b1;
                        state <= IDLE;
                    end else begin
                        drain_count <= drain_count + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_comb begin
        issue.valid = state == ISSUE && !is_stop;
        issue.instr = fetch_words[0];
        issue.constant = fetch_words[1];
        issue.channel = channel_t'(channel);
    end

    assign fetch_addr = pc;
    assign busy = state != IDLE;

endmodule

`default_nettype wire

//--- program_memory.sv
`timescale 1ns/100ps
`default_nettype none

module program_memory import core_isa_pkg::*; import core_bus_pkg::*; #(
    parameter int PROGRAM_DEPTH = 256,
    localparam int ADDR_WIDTH = $clog2(PROGRAM_DEPTH)
) (
    input  logic                  clock,
    input  logic                  wr_en,
    input  pm_index_t             wr_addr,
    input  logic [31:0]           wr_data,
    input  pm_index_t             rd_addr,
    input  logic [ADDR_WIDTH-1:0] fetch_addr,
    output logic [31:0]           rd_data,
    output instr_t [1:0]          fetch_words
);

    logic [31:0] mem [PROGRAM_DEPTH];
    logic [ADDR_WIDTH-1:0] next_addr;

    // The second fetch word wraps to the start of memory
    assign next_addr = (fetch_addr == ADDR_WIDTH'(PROGRAM_DEPTH - 1))
                     ? '0
                     : fetch_addr + 1'b1;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr[ADDR_WIDTH-1:0]] <= wr_data;
        end
    end

    // Host read port, data valid in the cycle after the address
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr[ADDR_WIDTH-1:0]];
    end

    // Fetch port returns the word at fetch_addr and the one after it
    always_ff @(posedge clock) begin
        fetch_words[0] <= instr_t'(mem[fetch_addr]);
        fetch_words[1] <= instr_t'(mem[next_addr]);
    end

endmodule

`default_nettype wire

//--- core_bus_pkg.sv
`default_nettype none

package core_bus_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [11:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Address regions, selected by adr bits 11:10
    localparam int REGION_MSB = 11;
    localparam int REGION_LSB = 10;
    localparam logic [1:0] REGION_PROGRAM = 2'd0;
    localparam logic [1:0] REGION_REGFILE = 2'd1;
    localparam logic [1:0] REGION_CONTROL = 2'd2;

    // Program memory word index within its region
    typedef logic [7:0] pm_index_t;

    // Register file fields within its region
    localparam int RF_CH_MSB  = 5;
    localparam int RF_CH_LSB  = 3;
    localparam int RF_REG_MSB = 2;
    localparam int RF_REG_LSB = 0;

    // Control register bits
    localparam int CTRL_RUN_BIT    = 8;
    localparam int STATUS_DONE_BIT = 16;
    localparam int STATUS_BUSY_BIT = 17;

endpackage

`default_nettype wire

//--- core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;

    // Each channel owns this many general registers
    localparam int NUM_REGS = 8;

    typedef logic [2:0] channel_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [4:0] {
        NOP  = 5'd0,
        ADD  = 5'd1,
        SUB  = 5'd2,
        AND  = 5'd3,
        OR   = 5'd4,
        XOR  = 5'd5,
        LDC  = 5'd6,
        LDCH = 5'd7,
        STOP = 5'd8
    } opcode_t;

    // Instruction word with the opcode in the low five bits
    typedef struct packed {
        logic [17:0] unused;
        reg_idx_t    rb;
        reg_idx_t    ra;
        reg_idx_t    rd;
        logic [4:0]  opcode;
    } instr_t;

    typedef struct packed {
        logic        valid;
        instr_t      instr;
        logic [31:0] constant;
        channel_t    channel;
    } issue_t;

    typedef struct packed {
        logic        valid;
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    ra;
        reg_idx_t    rb;
        channel_t    channel;
        logic [31:0] constant;
    } decoded_op_t;

    // Register file address, one register of one channel
    typedef struct packed {
        channel_t channel;
        reg_idx_t index;
    } rf_addr_t;

    typedef struct packed {
        logic        valid;
        channel_t    channel;
        reg_idx_t    rd;
        logic [31:0] value;
    } writeback_t;

endpackage

`default_nettype wire
